/* build.f */
rtl/memPkg.sv
rtl/loadStoreGate.sv
rtl/fetchPort.sv
rtl/memArbiter.sv
rtl/memController.sv
rtl/memSubsystem.sv
bench/memSubsystem_properties.sv
bench/memSubsystemTb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - rtl/memPkg.sv
  - rtl/loadStoreGate.sv
  - rtl/fetchPort.sv
  - rtl/memArbiter.sv
  - rtl/memController.sv
  - rtl/memSubsystem.sv
  - target: test
    files:
      - bench/memSubsystem_properties.sv
      - bench/memSubsystemTb.sv

/* bench/memSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;

    localparam int ClkPeriod      = 8;
    localparam int RespLimit      = 64;  // cycles before a wait gives up.
    localparam int NumRequests    = 2 + 6 + 4 + 3 + 2 + 16 + 40;
    localparam int WatchdogCycles = NumRequests * 20;
    localparam logic [memPkg::AddrWidth-1:0] RandBase = 32'h400;

    logic               clk;
    logic               rst;
    memPkg::lsReq_t     lsReq;
    logic               lsReqValid;
    logic               lsReqReady;
    memPkg::lsResp_t    lsResp;
    logic               lsRespValid;
    memPkg::fetchReq_t  fetchReq;
    logic               fetchReqValid;
    logic               fetchReqReady;
    memPkg::fetchResp_t fetchResp;
    logic               fetchRespValid;

    logic [7:0]  refMem [memPkg::MemBytes];  // reference memory, updated on every store.
    logic [31:0] lcgState;
    int          checks;
    int          errors;

    memSubsystem u_memSubsystem (
        .clk            (clk),
        .rst            (rst),
        .lsReq          (lsReq),
        .lsReqValid     (lsReqValid),
        .lsReqReady     (lsReqReady),
        .lsResp         (lsResp),
        .lsRespValid    (lsRespValid),
        .fetchReq       (fetchReq),
        .fetchReqValid  (fetchReqValid),
        .fetchReqReady  (fetchReqReady),
        .fetchResp      (fetchResp),
        .fetchRespValid (fetchRespValid)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int lenBytes(input memPkg::accessLen_t len);
        return (len == memPkg::LenByte) ? 1 : (len == memPkg::LenHalf) ? 2 : 4;
    endfunction

    function automatic logic [31:0] fillWord(input logic [memPkg::AddrWidth-1:0] addr);
        return (addr * 32'h9e3779b1) ^ 32'h5a5a5a5a;
    endfunction

    // little endian, lowest address holds the least significant byte.
    function automatic void modelStore(input logic [memPkg::AddrWidth-1:0] addr,
                                       input logic [memPkg::DataWidth-1:0] data,
                                       input memPkg::accessLen_t len);
        for (int i = 0; i < lenBytes(len); i++) begin
            refMem[(addr + i) % memPkg::MemBytes] = data[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] modelLoad(input logic [memPkg::AddrWidth-1:0] addr,
                                              input memPkg::accessLen_t len);
        logic [31:0] value;
        value = '0;  // zero extension.
        for (int i = 0; i < lenBytes(len); i++) begin
            value[8*i +: 8] = refMem[(addr + i) % memPkg::MemBytes];
        end
        return value;
    endfunction

    function automatic memPkg::lsReq_t makeReq(input logic write,
                                               input logic [memPkg::AddrWidth-1:0] addr,
                                               input logic [memPkg::DataWidth-1:0] data,
                                               input memPkg::accessLen_t len,
                                               input logic [memPkg::TagWidth-1:0] tag);
        memPkg::lsReq_t req;
        req.req.write = write;
        req.req.addr  = addr;
        req.req.wdata = data;
        req.req.len   = len;
        req.tag       = tag;
        return req;
    endfunction

    task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic reportFailure(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("%-18s %s (%0d errors)", name, (errors == errBefore) ? "ok" : "FAILED",
                 errors - errBefore);
    endtask

    // latency counts falling edges after the handshake edge.
    task automatic waitLsResp(output memPkg::lsResp_t resp, output int latency,
                              output bit sawReady);
        latency  = 0;
        sawReady = 1'b0;
        do begin
            @(negedge clk);
            latency++;
            sawReady |= lsReqReady;
        end while (!lsRespValid && latency < RespLimit);
        if (!lsRespValid) begin
            reportFailure("load/store response never arrived");
        end
        resp = lsResp;
    endtask

    task automatic lsAccess(input memPkg::lsReq_t req, output memPkg::lsResp_t resp,
                            output int latency);
        int waited;
        bit sawReady;
        @(posedge clk);
        lsReq      <= req;
        lsReqValid <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!lsReqReady && waited < RespLimit);
        if (!lsReqReady) begin
            reportFailure("lsReqReady never rose");
        end
        @(posedge clk);
        lsReqValid <= 1'b0;
        waitLsResp(resp, latency, sawReady);
    endtask

    task automatic fetchAccess(input logic [memPkg::AddrWidth-1:0] addr,
                               input logic [memPkg::TagWidth-1:0] tag,
                               output memPkg::fetchResp_t resp);
        int waited;
        @(posedge clk);
        fetchReq.addr <= addr;
        fetchReq.tag  <= tag;
        fetchReqValid <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!fetchReqReady && waited < RespLimit);
        if (!fetchReqReady) begin
            reportFailure("fetchReqReady never rose");
        end
        @(posedge clk);
        fetchReqValid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!fetchRespValid && waited < RespLimit);
        if (!fetchRespValid) begin
            reportFailure("fetch response never arrived");
        end
        resp = fetchResp;
    endtask

    task automatic doStore(input logic [memPkg::AddrWidth-1:0] addr,
                           input logic [memPkg::DataWidth-1:0] data,
                           input memPkg::accessLen_t len,
                           input logic [memPkg::TagWidth-1:0] tag, output int latency);
        memPkg::lsResp_t resp;
        lsAccess(makeReq(1'b1, addr, data, len, tag), resp, latency);
        modelStore(addr, data, len);
        checkEq(resp.rdata, 0, $sformatf("store response data at %h", addr));
        checkEq(resp.tag, tag, "store tag");
    endtask

    task automatic doLoad(input logic [memPkg::AddrWidth-1:0] addr,
                          input memPkg::accessLen_t len,
                          input logic [memPkg::TagWidth-1:0] tag, output int latency);
        memPkg::lsResp_t resp;
        lsAccess(makeReq(1'b0, addr, 32'h0, len, tag), resp, latency);
        checkEq(resp.rdata, modelLoad(addr, len), $sformatf("load data at %h", addr));
        checkEq(resp.tag, tag, "load tag");
    endtask

    task automatic doFetch(input logic [memPkg::AddrWidth-1:0] addr,
                           input logic [memPkg::TagWidth-1:0] tag);
        memPkg::fetchResp_t resp;
        fetchAccess(addr, tag, resp);
        checkEq(resp.instr, modelLoad(addr, memPkg::LenWord), $sformatf("fetch at %h", addr));
        checkEq(resp.tag, tag, "fetch tag");
    endtask

    task automatic wordStoreLoadTest();
        int errBefore;
        int lat;
        errBefore = errors;
        @(negedge clk);
        checkEq({lsReqReady, fetchReqReady}, 2'b11, "ready after reset");
        checkEq({lsRespValid, fetchRespValid}, 2'b00, "valid after reset");
        doStore(32'h40, 32'hdeadbeef, memPkg::LenWord, 4'h3, lat);
        checkEq(lat, 7, "idle word store latency");
        doLoad(32'h40, memPkg::LenWord, 4'h9, lat);
        checkEq(lat, 7, "idle word load latency");
        reportTest("word store/load", errBefore);
    endtask

    task automatic byteHalfTest();
        int errBefore;
        int lat;
        errBefore = errors;
        doStore(32'h80, 32'h11223344, memPkg::LenWord, 4'h1, lat);
        doStore(32'h81, 32'h555555ab, memPkg::LenByte, 4'h2, lat);  // upper bits ignored.
        doStore(32'h82, 32'h9999cdef, memPkg::LenHalf, 4'h3, lat);
        doLoad(32'h80, memPkg::LenWord, 4'h4, lat);
        doLoad(32'h81, memPkg::LenByte, 4'h5, lat);
        doLoad(32'h82, memPkg::LenHalf, 4'h6, lat);
        reportTest("byte/half", errBefore);
    endtask

    task automatic fetchTest();
        int errBefore;
        int lat;
        errBefore = errors;
        doStore(32'h200, 32'h00a00093, memPkg::LenWord, 4'h7, lat);
        doStore(32'h204, 32'h00b10113, memPkg::LenWord, 4'h8, lat);
        doFetch(32'h204, 4'h5);
        doFetch(32'h200, 4'h6);
        reportTest("fetch", errBefore);
    endtask

    task automatic contentionTest();
        int errBefore;
        int lat;
        errBefore = errors;
        doStore(32'h300, 32'hcafef00d, memPkg::LenWord, 4'h1, lat);
        fork
            doLoad(32'h40, memPkg::LenWord, 4'h7, lat);
            doFetch(32'h300, 4'hc);
        join
        reportTest("contention", errBefore);
    endtask

    task automatic backPressureTest();
        int              errBefore;
        int              waited;
        int              lat;
        bit              sawReady;
        memPkg::lsResp_t resp;
        errBefore = errors;
        @(posedge clk);
        lsReq      <= makeReq(1'b0, 32'h80, 32'h0, memPkg::LenWord, 4'h2);
        lsReqValid <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!lsReqReady && waited < RespLimit);
        if (!lsReqReady) begin
            reportFailure("lsReqReady never rose");
        end
        @(posedge clk);
        lsReq <= makeReq(1'b0, 32'h200, 32'h0, memPkg::LenWord, 4'ha);  // valid stays high.
        waitLsResp(resp, lat, sawReady);
        checkEq(sawReady, 1'b0, "lsReqReady low while load outstanding");
        checkEq(resp.rdata, modelLoad(32'h80, memPkg::LenWord), "first load data");
        checkEq(resp.tag, 4'h2, "first load tag");
        @(negedge clk);
        checkEq(lsReqReady, 1'b1, "lsReqReady back after response");
        @(posedge clk);
        lsReqValid <= 1'b0;
        waitLsResp(resp, lat, sawReady);
        checkEq(resp.rdata, modelLoad(32'h200, memPkg::LenWord), "second load data");
        checkEq(resp.tag, 4'ha, "second load tag");
        reportTest("back-pressure", errBefore);
    endtask

    task automatic randomTrafficTest();
        int                              errBefore;
        int                              lat;
        logic [31:0]                     r;
        logic [memPkg::AddrWidth-1:0]    addr;
        memPkg::accessLen_t              len;
        errBefore = errors;
        for (int i = 0; i < 16; i++) begin
            addr = RandBase + 4 * i;
            doStore(addr, fillWord(addr), memPkg::LenWord, i[3:0], lat);
        end
        for (int i = 0; i < 40; i++) begin
            r    = nextRand();
            len  = memPkg::accessLen_t'(r[9:8] % 3);
            addr = RandBase + (r[21:16] & ~(lenBytes(len) - 1));  // aligned, 64-byte window.
            case (r[29:28])
                2'd1:    doLoad(addr, len, r[3:0], lat);
                2'd2:    doFetch(RandBase + {r[21:18], 2'b00}, r[3:0]);
                default: doStore(addr, nextRand(), len, r[3:0], lat);
            endcase
        end
        reportTest("random traffic", errBefore);
    endtask

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("watchdog expired after %0d cycles, run stopped", WatchdogCycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        lsReq         = '0;
        lsReqValid    = 1'b0;
        fetchReq      = '0;
        fetchReqValid = 1'b0;
        lcgState      = 32'hc5f7;
        checks        = 0;
        errors        = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wordStoreLoadTest();
        byteHalfTest();
        fetchTest();
        contentionTest();
        backPressureTest();
        randomTrafficTest();
        if (u_memSubsystem.u_memSubsystemProperties.failures != 0) begin
            reportFailure($sformatf("%0d assertion failures in the bound checker",
                                    u_memSubsystem.u_memSubsystemProperties.failures));
        end
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/memSubsystem_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystemProperties (
    input logic              clk,
    input logic              rst,
    input memPkg::lsReq_t    lsReq,
    input logic              lsReqValid,
    input logic              lsReqReady,
    input logic              lsRespValid,
    input memPkg::fetchReq_t fetchReq,
    input logic              fetchReqValid,
    input logic              fetchReqReady,
    input logic              fetchRespValid
);

    logic lsStart;
    logic fetchStart;
    int   failures = 0; // failed assertions, read by the testbench.

    // idle means the other port has nothing in flight and nothing arriving.
    assign lsStart    = lsReqValid && lsReqReady && fetchReqReady && !fetchReqValid;
    assign fetchStart = fetchReqValid && fetchReqReady && lsReqReady && !lsReqValid;

    lsHold: assert property (@(posedge clk) disable iff (rst)
        lsReqValid && !lsReqReady |=> lsReqValid && $stable(lsReq))
        else begin
            $error("load/store request changed before it was accepted");
            failures++;
        end

    fetchHold: assert property (@(posedge clk) disable iff (rst)
        fetchReqValid && !fetchReqReady |=> fetchReqValid && $stable(fetchReq))
        else begin
            $error("fetch request changed before it was accepted");
            failures++;
        end

    lsPulse: assert property (@(posedge clk) disable iff (rst) lsRespValid |=> !lsRespValid)
        else begin
            $error("lsRespValid high for two cycles");
            failures++;
        end

    fetchPulse: assert property (@(posedge clk) disable iff (rst)
        fetchRespValid |=> !fetchRespValid)
        else begin
            $error("fetchRespValid high for two cycles");
            failures++;
        end

    // len+3 cycles from handshake to response.
    lsByteTime: assert property (@(posedge clk) disable iff (rst)
        lsStart && lsReq.req.len == memPkg::LenByte |-> ##3 !lsRespValid ##1 lsRespValid)
        else begin
            $error("idle byte access latency is not 4 cycles");
            failures++;
        end

    lsHalfTime: assert property (@(posedge clk) disable iff (rst)
        lsStart && lsReq.req.len == memPkg::LenHalf |-> ##4 !lsRespValid ##1 lsRespValid)
        else begin
            $error("idle half access latency is not 5 cycles");
            failures++;
        end

    lsWordTime: assert property (@(posedge clk) disable iff (rst)
        lsStart && lsReq.req.len == memPkg::LenWord |-> ##6 !lsRespValid ##1 lsRespValid)
        else begin
            $error("idle word access latency is not 7 cycles");
            failures++;
        end

    fetchTime: assert property (@(posedge clk) disable iff (rst)
        fetchStart |-> ##6 !fetchRespValid ##1 fetchRespValid)
        else begin
            $error("idle fetch latency is not 7 cycles");
            failures++;
        end

endmodule

bind memSubsystem memSubsystemProperties u_memSubsystemProperties (
    .clk            (clk),
    .rst            (rst),
    .lsReq          (lsReq),
    .lsReqValid     (lsReqValid),
    .lsReqReady     (lsReqReady),
    .lsRespValid    (lsRespValid),
    .fetchReq       (fetchReq),
    .fetchReqValid  (fetchReqValid),
    .fetchReqReady  (fetchReqReady),
    .fetchRespValid (fetchRespValid)
);

`default_nettype wire

/* rtl/memSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
    input  logic               clk,
    input  logic               rst,

    input  memPkg::lsReq_t     lsReq,
    input  logic               lsReqValid,
    output logic               lsReqReady,
    output memPkg::lsResp_t    lsResp,
    output logic               lsRespValid,

    input  memPkg::fetchReq_t  fetchReq,
    input  logic               fetchReqValid,
    output logic               fetchReqReady,
    output memPkg::fetchResp_t fetchResp,
    output logic               fetchRespValid
);

    memPkg::memReq_t  lsMemReq;
    logic             lsMemReqValid;
    logic             lsMemReqReady;
    logic             lsMemRespValid;
    memPkg::memReq_t  fetchMemReq;
    logic             fetchMemReqValid;
    logic             fetchMemReqReady;
    logic             fetchMemRespValid;
    memPkg::memResp_t memResp;
    memPkg::memReq_t  ctrlReq;
    logic             ctrlReqValid;
    logic             ctrlReqReady;
    memPkg::memResp_t ctrlResp;
    logic             ctrlDone;

    loadStoreGate u_loadStoreGate (
        .clk          (clk),
        .rst          (rst),
        .lsReq        (lsReq),
        .lsReqValid   (lsReqValid),
        .lsReqReady   (lsReqReady),
        .lsResp       (lsResp),
        .lsRespValid  (lsRespValid),
        .memReq       (lsMemReq),
        .memReqValid  (lsMemReqValid),
        .memReqReady  (lsMemReqReady),
        .memResp      (memResp),
        .memRespValid (lsMemRespValid)
    );

    fetchPort u_fetchPort (
        .clk            (clk),
        .rst            (rst),
        .fetchReq       (fetchReq),
        .fetchReqValid  (fetchReqValid),
        .fetchReqReady  (fetchReqReady),
        .fetchResp      (fetchResp),
        .fetchRespValid (fetchRespValid),
        .memReq         (fetchMemReq),
        .memReqValid    (fetchMemReqValid),
        .memReqReady    (fetchMemReqReady),
        .memResp        (memResp),
        .memRespValid   (fetchMemRespValid)
    );

    memArbiter u_memArbiter (
        .clk               (clk),
        .rst               (rst),
        .lsMemReq          (lsMemReq),
        .lsMemReqValid     (lsMemReqValid),
        .lsMemReqReady     (lsMemReqReady),
        .lsMemRespValid    (lsMemRespValid),
        .fetchMemReq       (fetchMemReq),
        .fetchMemReqValid  (fetchMemReqValid),
        .fetchMemReqReady  (fetchMemReqReady),
        .fetchMemRespValid (fetchMemRespValid),
        .memResp           (memResp),
        .ctrlReq           (ctrlReq),
        .ctrlReqValid      (ctrlReqValid),
        .ctrlReqReady      (ctrlReqReady),
        .ctrlResp          (ctrlResp),
        .ctrlDone          (ctrlDone)
    );

    memController u_memController (
        .clk      (clk),
        .rst      (rst),
        .req      (ctrlReq),
        .reqValid (ctrlReqValid),
        .reqReady (ctrlReqReady),
        .resp     (ctrlResp),
        .done     (ctrlDone)
    );

endmodule

`default_nettype wire

/* rtl/memController.sv */
`timescale 1ns/1ps
`default_nettype none

module memController (
    input  logic             clk,
    input  logic             rst,

    input  memPkg::memReq_t  req,
    input  logic             reqValid,
    output logic             reqReady,

    output memPkg::memResp_t resp,
    output logic             done
);

    logic [7:0] mem [memPkg::MemBytes];

    memPkg::memReq_t                 cur;
    logic                            busy;
    logic [1:0]                      byteIdx;
    logic [1:0]                      lastIdx;
    logic                            lastByte;
    logic                            accept;
    logic [memPkg::RamAddrWidth-1:0] byteOffset;
    logic [memPkg::RamAddrWidth-1:0] byteAddr;
    logic [7:0]                      rdByte;
    logic [7:0]                      wrByte;
    logic [memPkg::DataWidth-1:0]    rdWord;
    logic [memPkg::DataWidth-1:0]    nextWord;

    assign reqReady = !busy;
    assign accept   = reqValid && reqReady;

    always_comb begin
        case (cur.len)
            memPkg::LenByte: lastIdx = 2'd0;
            memPkg::LenHalf: lastIdx = 2'd1;
            default:         lastIdx = 2'd3;
        endcase
    end

    assign lastByte   = busy && (byteIdx == lastIdx);
    assign byteOffset = {{(memPkg::RamAddrWidth-2){1'b0}}, byteIdx};
    assign byteAddr   = cur.addr[memPkg::RamAddrWidth-1:0] + byteOffset; // little endian.
    assign rdByte     = mem[byteAddr];
    assign wrByte     = cur.wdata[byteIdx*8 +: 8];

    always_comb begin
        nextWord                 = rdWord;
        nextWord[byteIdx*8 +: 8] = rdByte;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            byteIdx <= 2'd0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy    <= 1'b1;
                byteIdx <= 2'd0;
            end else if (busy) begin
                byteIdx <= byteIdx + 2'd1;
                if (lastByte) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur    <= req;
            rdWord <= '0; // upper bytes stay zero for short loads.
        end else if (busy && !cur.write) begin
            rdWord <= nextWord;
        end
    end

    always_ff @(posedge clk) begin
        if (busy && cur.write) begin
            mem[byteAddr] <= wrByte;
        end
    end

    always_ff @(posedge clk) begin
        if (lastByte) begin
            resp.rdata <= cur.write ? '0 : nextWord;
        end
    end

endmodule

`default_nettype wire

/* rtl/memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  logic             clk,
    input  logic             rst,

    input  memPkg::memReq_t  lsMemReq,
    input  logic             lsMemReqValid,
    output logic             lsMemReqReady,
    output logic             lsMemRespValid,

    input  memPkg::memReq_t  fetchMemReq,
    input  logic             fetchMemReqValid,
    output logic             fetchMemReqReady,
    output logic             fetchMemRespValid,

    output memPkg::memResp_t memResp,

    output memPkg::memReq_t  ctrlReq,
    output logic             ctrlReqValid,
    input  logic             ctrlReqReady,

    input  memPkg::memResp_t ctrlResp,
    input  logic             ctrlDone
);

    logic locked;     // controller belongs to owner until done.
    logic owner;      // 1 when the fetch port holds the controller.
    logic lastFetch;  // fetch port was served last.
    logic grantFetch;
    logic granted;

    always_comb begin
        if (lsMemReqValid && fetchMemReqValid) begin
            grantFetch = !lastFetch; // round robin on a tie.
        end else begin
            grantFetch = fetchMemReqValid;
        end
    end

    assign ctrlReqValid = !locked && (lsMemReqValid || fetchMemReqValid);
    assign ctrlReq      = grantFetch ? fetchMemReq : lsMemReq;
    assign granted      = ctrlReqValid && ctrlReqReady;

    assign lsMemReqReady    = !locked && ctrlReqReady && !grantFetch;
    assign fetchMemReqReady = !locked && ctrlReqReady && grantFetch;

    // done is steered only to the port that owns the access.
    assign memResp           = ctrlResp;
    assign lsMemRespValid    = ctrlDone && locked && !owner;
    assign fetchMemRespValid = ctrlDone && locked && owner;

    always_ff @(posedge clk) begin
        if (rst) begin
            locked    <= 1'b0;
            owner     <= 1'b0;
            lastFetch <= 1'b1; // load/store wins the first tie.
        end else begin
            if (granted) begin
                locked    <= 1'b1;
                owner     <= grantFetch;
                lastFetch <= grantFetch;
            end else if (ctrlDone) begin
                locked <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/fetchPort.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchPort (
    input  logic               clk,
    input  logic               rst,

    input  memPkg::fetchReq_t  fetchReq,
    input  logic               fetchReqValid,
    output logic               fetchReqReady,

    output memPkg::fetchResp_t fetchResp,
    output logic               fetchRespValid,

    output memPkg::memReq_t    memReq,
    output logic               memReqValid,
    input  logic               memReqReady,

    input  memPkg::memResp_t   memResp,
    input  logic               memRespValid
);

    logic                        busy;
    logic [memPkg::TagWidth-1:0] heldTag;
    logic                        accept;

    assign fetchReqReady = !busy;
    assign accept        = fetchReqValid && fetchReqReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy           <= 1'b0;
            memReqValid    <= 1'b0;
            fetchRespValid <= 1'b0;
        end else begin
            fetchRespValid <= memRespValid;
            if (accept) begin
                busy        <= 1'b1;
                memReqValid <= 1'b1;
            end else begin
                if (memReqValid && memReqReady) begin
                    memReqValid <= 1'b0;
                end
                if (fetchRespValid) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // instruction fetch is always a full word read.
    always_ff @(posedge clk) begin
        if (accept) begin
            memReq.write <= 1'b0;
            memReq.addr  <= fetchReq.addr;
            memReq.wdata <= '0;
            memReq.len   <= memPkg::LenWord;
            heldTag      <= fetchReq.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (memRespValid) begin
            fetchResp.instr <= memResp.rdata;
            fetchResp.tag   <= heldTag;
        end
    end

endmodule

`default_nettype wire

/* rtl/loadStoreGate.sv */
`timescale 1ns/1ps
`default_nettype none

module loadStoreGate (
    input  logic             clk,
    input  logic             rst,

    input  memPkg::lsReq_t   lsReq,
    input  logic             lsReqValid,
    output logic             lsReqReady,

    output memPkg::lsResp_t  lsResp,
    output logic             lsRespValid,

    output memPkg::memReq_t  memReq,
    output logic             memReqValid,
    input  logic             memReqReady,

    input  memPkg::memResp_t memResp,
    input  logic             memRespValid
);

    logic                        busy;
    logic [memPkg::TagWidth-1:0] heldTag;
    logic                        accept;

    assign lsReqReady = !busy;
    assign accept     = lsReqValid && lsReqReady;

    // busy spans from acceptance to the end of the response cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            memReqValid <= 1'b0;
            lsRespValid <= 1'b0;
        end else begin
            lsRespValid <= memRespValid;
            if (accept) begin
                busy        <= 1'b1;
                memReqValid <= 1'b1;
            end else begin
                if (memReqValid && memReqReady) begin
                    memReqValid <= 1'b0; // granted, wait for data.
                end
                if (lsRespValid) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            memReq  <= lsReq.req;
            heldTag <= lsReq.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (memRespValid) begin
            lsResp.rdata <= memResp.rdata;
            lsResp.tag   <= heldTag; // tag returns with the data.
        end
    end

endmodule

`default_nettype wire

/* rtl/memPkg.sv */
`default_nettype none

package memPkg;

    localparam int MemBytes     = 4096;
    localparam int AddrWidth    = 32;
    localparam int DataWidth    = 32;
    localparam int TagWidth     = 4;
    localparam int RamAddrWidth = $clog2(MemBytes); // low address bits that reach the RAM.

    typedef enum logic [1:0] {
        LenByte = 2'd0,
        LenHalf = 2'd1,
        LenWord = 2'd2
    } accessLen_t;

    typedef struct packed {
        logic                 write;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
        accessLen_t           len;
    } memReq_t;

    typedef struct packed {
        logic [DataWidth-1:0] rdata; // zero-extended, zero for stores.
    } memResp_t;

    typedef struct packed {
        memReq_t             req;
        logic [TagWidth-1:0] tag;
    } lsReq_t;

    typedef struct packed {
        logic [DataWidth-1:0] rdata;
        logic [TagWidth-1:0]  tag;
    } lsResp_t;

    typedef struct packed {
        logic [AddrWidth-1:0] addr;
        logic [TagWidth-1:0]  tag;
    } fetchReq_t;

    typedef struct packed {
        logic [DataWidth-1:0] instr;
        logic [TagWidth-1:0]  tag;
    } fetchResp_t;

endpackage

`default_nettype wire
